// File: verilog.f
+incdir+bench
common/pim_pkg.sv
source/pim_bus_decode.sv
sequencer/pulse_timer.sv
sequencer/read_timer.sv
sequencer/pim_sequencer.sv
source/pim_ctrl_top.sv
bench/tb_pim_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PIM controller testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing \
    --timescale 1ns/1ps \
    -Wno-fatal \
    --top-module tb_pim_ctrl \
    -Mdir "$BUILD_DIR" \
    -o sim_tb_pim_ctrl \
    -f verilog.f

"./$BUILD_DIR/sim_tb_pim_ctrl" | tee "$LOG_FILE"

if grep -qx "all tests passed" "$LOG_FILE"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG_FILE"
    exit 1
fi

// File: bench/pim_tests.svh
`ifndef PIM_TESTS_SVH
`define PIM_TESTS_SVH

// All cell array outputs at rest
task automatic check_quiet();
    check_value("pim_en_o", pim_en, 0);
    check_value("pim_mode_o", pim_mode, MODE_IDLE);
    check_value("row_addr_o", row_addr, 0);
    check_value("col_addr_o", col_addr, 0);
    check_value("exec_cnt_o", exec_cnt, 0);
    check_value("zp_en_o", zp_en, 0);
    check_value("zp_data_o", zp_data, 0);
    check_value("out_buf_rd_en_o", out_buf_rd_en, 0);
    check_value("proc_done_o", proc_done, 0);
endtask

// Status lands on data_o one cycle after the address
task automatic read_status(input logic [31:0] expected);
    bus_cycle(STATUS_ADDR, '0);
    bus_cycle('0, '0);
    check_value("data_o", rdata, expected);
endtask

task automatic reset_idle_status();
    bus_cycle('0, '0);
    check_quiet();
    check_value("data_o", rdata, 0);
    read_status(32'h3);
endtask

task automatic run_pulse_train(input logic [2:0] mode, input int width, input int count,
                               input bit write_mid_run);
    logic [31:0] bits;
    logic [6:0]  row;
    logic [8:0]  col;
    logic        prev_en;
    int          n;
    int          runs;
    int          highs;
    int          run_len;
    rand_bits(7, bits);
    row = bits[6:0];
    rand_bits(9, bits);
    col = bits[8:0];
    n = 0;
    runs = 0;
    highs = 0;
    run_len = 0;
    prev_en = 1'b0;
    bus_cycle(MODE_ADDR, {29'b0, mode});
    check_value("pim_en_o", pim_en, 0);
    bus_cycle({CELL_PAGE, row, col}, {10'b0, 17'(width), 5'(count)});
    check_value("pim_en_o", pim_en, 0);
    bus_cycle(STATUS_ADDR, '0);
    while (pim_mode != MODE_IDLE && n < MAX_TRAIN + 8) begin
        check_value("pim_mode_o", pim_mode, mode);
        check_value("row_addr_o", row_addr, row);
        check_value("col_addr_o", col_addr, col);
        if (n == 1) begin
            check_value("data_o", rdata, 32'h2);
        end
        if (pim_en) begin
            highs++;
            run_len++;
            if (!prev_en) begin
                runs++;
            end
        end else if (prev_en) begin
            check_value("pulse width", run_len, width);
            run_len = 0;
        end
        prev_en = pim_en;
        n++;
        if (write_mid_run && n == 2) begin
            bus_cycle(MODE_ADDR, {29'b0, MODE_READ});
        end else begin
            bus_cycle('0, '0);
        end
    end
    check_value("exec cycles", n, count * (width + 1));
    check_value("pulse count", runs, count);
    check_value("high cycles", highs, count * width);
    read_status(32'h3);
endtask

task automatic random_pulse_trains();
    logic [31:0] bits;
    int          t;
    int          width;
    int          count;
    for (t = 0; t < NUM_TRAINS; t++) begin
        rand_bits(3, bits);
        width = int'(bits % 6) + 1;
        rand_bits(2, bits);
        count = int'(bits) + 1;
        run_pulse_train((t % 2 == 1) ? MODE_PROGRAM : MODE_ERASE, width, count, 1'b0);
    end
endtask

task automatic read_operation();
    logic [31:0] bits;
    int          i;
    rand_bits(16, bits);
    bus_cycle(MODE_ADDR, {29'b0, MODE_READ});
    bus_cycle({CELL_PAGE, bits[15:0]}, '0);
    check_value("pim_en_o", pim_en, 0);
    for (i = 0; i < READ_CYCLES; i++) begin
        bus_cycle('0, '0);
        check_value("pim_en_o", pim_en, 1);
        check_value("exec_cnt_o", exec_cnt, READ_CYCLES - i);
        check_value("pim_mode_o", pim_mode, MODE_READ);
        check_value("row_addr_o", row_addr, bits[15:9]);
        check_value("col_addr_o", col_addr, bits[8:0]);
    end
    // Countdown drained, one quiet cycle before processing
    bus_cycle('0, '0);
    check_quiet();
    for (i = 0; i < 3; i++) begin
        bus_cycle('0, '0);
        check_value("pim_mode_o", pim_mode, MODE_READ);
        check_value("pim_en_o", pim_en, 0);
        check_value("out_buf_rd_en_o", out_buf_rd_en, (i < 2) ? 1 : 0);
        check_value("proc_done_o", proc_done, (i == 1) ? 1 : 0);
    end
    bus_cycle('0, '0);
    check_quiet();
    read_status(32'h3);
endtask

task automatic zero_point_write();
    logic [31:0] value;
    rand_bits(32, value);
    bus_cycle(MODE_ADDR, {29'b0, MODE_ZP});
    check_value("zp_en_o", zp_en, 0);
    bus_cycle(ZP_ADDR, value);
    check_value("zp_en_o", zp_en, 1);
    check_value("zp_data_o", zp_data, value);
    check_value("pim_en_o", pim_en, 0);
    bus_cycle('0, '0);
    check_quiet();
    read_status(32'h3);
    check_value("pim_en_o", pim_en, 0);
endtask

task automatic ignored_writes();
    int i;
    // Code 6 is not a kept mode
    bus_cycle(MODE_ADDR, 32'h6);
    read_status(32'h3);
    bus_cycle({CELL_PAGE, 7'h15, 9'h0a3}, {10'b0, 17'd3, 5'd2});
    check_value("pim_en_o", pim_en, 0);
    for (i = 0; i < 4; i++) begin
        bus_cycle('0, '0);
        check_quiet();
    end
    run_pulse_train(MODE_ERASE, 4, 2, 1'b1);
endtask

`endif

// File: bench/tb_pim_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pim_ctrl;

    localparam int          HALF_PERIOD  = 4;
    localparam int          CLK_PERIOD   = 2 * HALF_PERIOD;
    localparam int          RESET_CYCLES = 5;
    localparam logic [31:0] SEED         = 32'he7f5_cd7a;

    localparam logic [31:0] MODE_ADDR   = 32'h4100_0000;
    localparam logic [31:0] ZP_ADDR     = 32'h4200_0000;
    localparam logic [31:0] STATUS_ADDR = 32'h4300_0000;
    localparam logic [15:0] CELL_PAGE   = 16'h4000;
    localparam int          READ_CYCLES = 9;

    localparam logic [2:0] MODE_IDLE    = 3'd0;
    localparam logic [2:0] MODE_ERASE   = 3'd1;
    localparam logic [2:0] MODE_PROGRAM = 3'd2;
    localparam logic [2:0] MODE_READ    = 3'd3;
    localparam logic [2:0] MODE_ZP      = 3'd4;

    // Longest random train is 4 pulses of 6 cycles plus gaps
    localparam int NUM_TRAINS  = 4;
    localparam int MAX_TRAIN   = 4 * (6 + 1);
    localparam int WATCHDOG_NS = ((NUM_TRAINS + 2) * (MAX_TRAIN + 8) + 120) * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    logic [31:0] address;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        pim_en;
    logic [2:0]  pim_mode;
    logic [6:0]  row_addr;
    logic [8:0]  col_addr;
    logic [3:0]  exec_cnt;
    logic        zp_en;
    logic [31:0] zp_data;
    logic        out_buf_rd_en;
    logic        proc_done;

    int          errors;
    int          checks;
    logic [31:0] lfsr_state;

    pim_ctrl_top #(
        .MODE_ADDR   (MODE_ADDR),
        .ZP_ADDR     (ZP_ADDR),
        .STATUS_ADDR (STATUS_ADDR),
        .READ_CYCLES (READ_CYCLES)
    ) uut (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .address_i       (address),
        .data_i          (wdata),
        .data_o          (rdata),
        .pim_en_o        (pim_en),
        .pim_mode_o      (pim_mode),
        .row_addr_o      (row_addr),
        .col_addr_o      (col_addr),
        .exec_cnt_o      (exec_cnt),
        .zp_en_o         (zp_en),
        .zp_data_o       (zp_data),
        .out_buf_rd_en_o (out_buf_rd_en),
        .proc_done_o     (proc_done)
    );

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int nbits, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h at %0t",
                     name, actual, expected, $time);
        end
    endtask

    // Inputs change on the falling edge, outputs are sampled 1 ns later
    task automatic bus_cycle(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        address = addr;
        wdata   = data;
        #1;
    endtask

    `include "pim_tests.svh"

    initial begin
        errors     = 0;
        checks     = 0;
        lfsr_state = SEED;
        rst_n      = 1'b0;
        address    = '0;
        wdata      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_idle_status();
        random_pulse_trains();
        read_operation();
        zero_point_write();
        ignored_writes();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/pim_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module pim_ctrl_top #(
    parameter pim_pkg::bus_word_t MODE_ADDR   = 32'h4100_0000,
    parameter pim_pkg::bus_word_t ZP_ADDR     = 32'h4200_0000,
    parameter pim_pkg::bus_word_t STATUS_ADDR = 32'h4300_0000,
    parameter int unsigned        READ_CYCLES = 9
) (
    input  logic                clk_i,
    input  logic                rst_ni,

    // Processor bus
    input  pim_pkg::bus_word_t  address_i,
    input  pim_pkg::bus_word_t  data_i,
    output pim_pkg::bus_word_t  data_o,

    // Cell array drive
    output logic                pim_en_o,
    output pim_pkg::pim_mode_e  pim_mode_o,
    output pim_pkg::row_addr_t  row_addr_o,
    output pim_pkg::col_addr_t  col_addr_o,
    output pim_pkg::exec_cnt_t  exec_cnt_o,

    output logic                zp_en_o,
    output pim_pkg::bus_word_t  zp_data_o,

    // Output buffer processing
    output logic                out_buf_rd_en_o,
    output logic                proc_done_o
);
    import pim_pkg::*;

    logic      mode_wr;
    logic      cell_wr;
    logic      zp_wr;
    logic      seq_idle;
    logic      pulse_start;
    logic      read_start;
    logic      pulse_on;
    logic      pulse_last;
    exec_cnt_t exec_cnt;
    logic      exec_done;
    logic      proc_rd;
    logic      proc_last;

    pim_bus_decode #(
        .MODE_ADDR   (MODE_ADDR),
        .ZP_ADDR     (ZP_ADDR),
        .STATUS_ADDR (STATUS_ADDR)
    ) u_bus_decode (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .address_i  (address_i),
        .seq_idle_i (seq_idle),
        .mode_wr_o  (mode_wr),
        .cell_wr_o  (cell_wr),
        .zp_wr_o    (zp_wr),
        .data_o     (data_o)
    );

    pim_sequencer u_sequencer (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .address_i       (address_i),
        .data_i          (data_i),
        .mode_wr_i       (mode_wr),
        .cell_wr_i       (cell_wr),
        .zp_wr_i         (zp_wr),
        .pulse_on_i      (pulse_on),
        .pulse_last_i    (pulse_last),
        .exec_cnt_i      (exec_cnt),
        .exec_done_i     (exec_done),
        .proc_rd_i       (proc_rd),
        .proc_last_i     (proc_last),
        .seq_idle_o      (seq_idle),
        .pulse_start_o   (pulse_start),
        .read_start_o    (read_start),
        .pim_en_o        (pim_en_o),
        .pim_mode_o      (pim_mode_o),
        .row_addr_o      (row_addr_o),
        .col_addr_o      (col_addr_o),
        .exec_cnt_o      (exec_cnt_o),
        .zp_en_o         (zp_en_o),
        .zp_data_o       (zp_data_o),
        .out_buf_rd_en_o (out_buf_rd_en_o),
        .proc_done_o     (proc_done_o)
    );

    pulse_timer u_pulse_timer (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .pulse_start_i (pulse_start),
        .data_i        (data_i),
        .pulse_on_o    (pulse_on),
        .pulse_last_o  (pulse_last)
    );

    read_timer #(
        .READ_CYCLES (READ_CYCLES)
    ) u_read_timer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .read_start_i (read_start),
        .exec_cnt_o   (exec_cnt),
        .exec_done_o  (exec_done),
        .proc_rd_o    (proc_rd),
        .proc_last_o  (proc_last)
    );

endmodule

`default_nettype wire

// File: sequencer/pim_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pim_sequencer (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  pim_pkg::bus_word_t  address_i,
    input  pim_pkg::bus_word_t  data_i,
    input  logic                mode_wr_i,
    input  logic                cell_wr_i,
    input  logic                zp_wr_i,

    // From the timers
    input  logic                pulse_on_i,
    input  logic                pulse_last_i,
    input  pim_pkg::exec_cnt_t  exec_cnt_i,
    input  logic                exec_done_i,
    input  logic                proc_rd_i,
    input  logic                proc_last_i,

    output logic                seq_idle_o,
    output logic                pulse_start_o,
    output logic                read_start_o,

    output logic                pim_en_o,
    output pim_pkg::pim_mode_e  pim_mode_o,
    output pim_pkg::row_addr_t  row_addr_o,
    output pim_pkg::col_addr_t  col_addr_o,
    output pim_pkg::exec_cnt_t  exec_cnt_o,
    output logic                zp_en_o,
    output pim_pkg::bus_word_t  zp_data_o,
    output logic                out_buf_rd_en_o,
    output logic                proc_done_o
);
    import pim_pkg::*;

    seq_state_e state_q;
    seq_state_e state_d;
    pim_mode_e  mode_q;
    pim_mode_e  mode_req;
    row_addr_t  row_q;
    col_addr_t  col_q;
    logic       mode_ok;
    logic       mode_accept;
    logic       is_pulse_mode;
    logic       cell_setup;
    logic       setup_done;

    assign mode_req = pim_mode_e'(data_i[2:0]);

    always_comb begin
        case (mode_req)
            PIM_ERASE, PIM_PROGRAM, PIM_READ, PIM_ZP: mode_ok = 1'b1;
            default:                                  mode_ok = 1'b0;
        endcase
    end

    assign seq_idle_o    = (state_q == ST_IDLE);
    assign mode_accept   = seq_idle_o && mode_wr_i && mode_ok;
    assign is_pulse_mode = (mode_q == PIM_ERASE) || (mode_q == PIM_PROGRAM);

    // Cell write while waiting in setup
    assign cell_setup    = (state_q == ST_SETUP) && cell_wr_i;
    assign pulse_start_o = cell_setup && is_pulse_mode;
    assign read_start_o  = cell_setup && (mode_q == PIM_READ);

    assign setup_done = pulse_start_o || read_start_o ||
                        ((state_q == ST_SETUP) && (mode_q == PIM_ZP) && zp_wr_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
            mode_q  <= PIM_IDLE_MODE;
        end else begin
            state_q <= state_d;
            if (mode_accept) begin
                mode_q <= mode_req;
            end
        end
    end

    // Target cell
    always_ff @(posedge clk_i) begin
        if (cell_setup) begin
            row_q <= address_i[15:9];
            col_q <= address_i[8:0];
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (mode_accept) begin
                    state_d = ST_SETUP;
                end
            end
            ST_SETUP: begin
                if (setup_done) begin
                    state_d = (mode_q == PIM_ZP) ? ST_IDLE : ST_EXEC;
                end
            end
            ST_EXEC: begin
                if (is_pulse_mode) begin
                    if (pulse_last_i) begin
                        state_d = ST_IDLE;
                    end
                end else if (mode_q == PIM_READ) begin
                    if (exec_done_i) begin
                        state_d = ST_PROCESS;
                    end
                end else begin
                    state_d = ST_IDLE;
                end
            end
            ST_PROCESS: begin
                // Third processing cycle has the read strobe low
                if (!proc_rd_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_comb begin
        pim_en_o        = 1'b0;
        pim_mode_o      = PIM_IDLE_MODE;
        row_addr_o      = '0;
        col_addr_o      = '0;
        exec_cnt_o      = '0;
        zp_en_o         = 1'b0;
        zp_data_o       = '0;
        out_buf_rd_en_o = 1'b0;
        proc_done_o     = 1'b0;
        case (state_q)
            ST_SETUP: begin
                if ((mode_q == PIM_ZP) && zp_wr_i) begin
                    zp_en_o   = 1'b1;
                    zp_data_o = data_i;
                end
            end
            ST_EXEC: begin
                if (is_pulse_mode) begin
                    // Address and mode held across the low gaps too
                    pim_en_o   = pulse_on_i;
                    pim_mode_o = mode_q;
                    row_addr_o = row_q;
                    col_addr_o = col_q;
                end else if ((mode_q == PIM_READ) && !exec_done_i) begin
                    pim_en_o   = 1'b1;
                    pim_mode_o = mode_q;
                    row_addr_o = row_q;
                    col_addr_o = col_q;
                    exec_cnt_o = exec_cnt_i;
                end
            end
            ST_PROCESS: begin
                pim_mode_o      = mode_q;
                out_buf_rd_en_o = proc_rd_i;
                proc_done_o     = proc_last_i;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: sequencer/read_timer.sv
`timescale 1ns/1ps
`default_nettype none

module read_timer #(
    parameter int unsigned READ_CYCLES = 9
) (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  logic                read_start_i,

    output pim_pkg::exec_cnt_t  exec_cnt_o,
    output logic                exec_done_o,
    output logic                proc_rd_o,
    output logic                proc_last_o
);
    import pim_pkg::*;

    exec_cnt_t  exec_q;
    logic [1:0] proc_q;
    logic       proc_pend_q;
    logic       proc_start;

    // Countdown has drained and processing is still owed
    assign proc_start = proc_pend_q && (exec_q == '0) && !read_start_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            exec_q      <= '0;
            proc_pend_q <= 1'b0;
            proc_q      <= '0;
        end else begin
            if (read_start_i) begin
                exec_q <= exec_cnt_t'(READ_CYCLES);
            end else if (exec_q != '0) begin
                exec_q <= exec_q - 1'b1;
            end

            if (read_start_i) begin
                proc_pend_q <= 1'b1;
            end else if (proc_start) begin
                proc_pend_q <= 1'b0;
            end

            // 3 and 2 read the buffer, 1 is the closing cycle
            if (proc_start) begin
                proc_q <= 2'd3;
            end else if (proc_q != '0) begin
                proc_q <= proc_q - 1'b1;
            end
        end
    end

    assign exec_cnt_o  = exec_q;
    assign exec_done_o = (exec_q == '0);
    assign proc_rd_o   = proc_q[1];
    assign proc_last_o = (proc_q == 2'd2);

endmodule

`default_nettype wire

// File: sequencer/pulse_timer.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_timer (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  logic                pulse_start_i,
    input  pim_pkg::bus_word_t  data_i,

    output logic                pulse_on_o,
    output logic                pulse_last_o
);
    import pim_pkg::*;

    pulse_width_t width_in;
    pulse_count_t count_in;
    pulse_width_t width_rld_q;
    pulse_width_t width_q;
    pulse_count_t count_q;

    assign width_in = data_i[21:5];
    assign count_in = data_i[4:0];

    always_ff @(posedge clk_i) begin
        if (pulse_start_i) begin
            width_rld_q <= width_in;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            width_q <= '0;
            count_q <= '0;
        end else if (pulse_start_i) begin
            count_q <= count_in;
            // Zero count gives a single low cycle
            width_q <= (count_in == '0) ? '0 : width_in;
        end else if (count_q != '0) begin
            if (width_q != '0) begin
                width_q <= width_q - 1'b1;
            end else begin
                count_q <= count_q - 1'b1;
                // No reload after the final pulse
                if (count_q != 5'd1) begin
                    width_q <= width_rld_q;
                end
            end
        end
    end

    assign pulse_on_o   = (width_q != '0);
    assign pulse_last_o = (count_q <= 5'd1) && (width_q == '0);

endmodule

`default_nettype wire

// File: source/pim_bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module pim_bus_decode #(
    parameter pim_pkg::bus_word_t MODE_ADDR   = 32'h4100_0000,
    parameter pim_pkg::bus_word_t ZP_ADDR     = 32'h4200_0000,
    parameter pim_pkg::bus_word_t STATUS_ADDR = 32'h4300_0000
) (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  pim_pkg::bus_word_t  address_i,
    input  logic                seq_idle_i,

    // One-cycle write strobes
    output logic                mode_wr_o,
    output logic                cell_wr_o,
    output logic                zp_wr_o,

    output pim_pkg::bus_word_t  data_o
);
    import pim_pkg::*;

    logic      status_rd;
    bus_word_t status_word;

    // No valid strobe on this bus, a matching address is the write
    assign mode_wr_o = (address_i == MODE_ADDR);
    assign zp_wr_o   = (address_i == ZP_ADDR);
    assign status_rd = (address_i == STATUS_ADDR);

    // Row and column ride in the low half
    assign cell_wr_o = (address_i[31:16] == CELL_PAGE);

    // Bit 1 is always set, bit 0 shows the sequencer is free
    assign status_word = {30'b0, 1'b1, seq_idle_i};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            data_o <= '0;
        end else if (status_rd) begin
            data_o <= status_word;
        end else begin
            data_o <= '0;
        end
    end

endmodule

`default_nettype wire

// File: common/pim_pkg.sv
`default_nettype none

package pim_pkg;

    // Processor bus word, used for both address and data
    typedef logic [31:0] bus_word_t;

    // Operation codes as written to the mode register
    typedef enum logic [2:0] {
        PIM_IDLE_MODE = 3'd0,
        PIM_ERASE     = 3'd1,
        PIM_PROGRAM   = 3'd2,
        PIM_READ      = 3'd3,
        PIM_ZP        = 3'd4
    } pim_mode_e;

    // Sequencer FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_EXEC,
        ST_PROCESS
    } seq_state_e;

    // Cell address fields, taken from address bits 15:9 and 8:0
    typedef logic [6:0] row_addr_t;
    typedef logic [8:0] col_addr_t;

    // Pulse fields, taken from data bits 21:5 and 4:0
    typedef logic [16:0] pulse_width_t;
    typedef logic [4:0]  pulse_count_t;

    // Read execution countdown
    typedef logic [3:0] exec_cnt_t;

    // Upper address half of a cell write
    localparam logic [15:0] CELL_PAGE = 16'h4000;

endpackage

`default_nettype wire
